// ==== Makefile ====
TOP = tb_conv_layer

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f flist.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^Simulation passed$$"

clean:
	rm -rf obj_dir

// ==== conv_accum.sv ====
`timescale 1ns/1ps

module conv_accum (
   input  logic                                       clk,
   input  logic                                       rst_n,
   input  logic                                       part_valid_i,
   input  logic [conv_pkg::CH_IN-1:0][conv_pkg::FILTERS-1:0]
                [conv_pkg::POS_OUT-1:0][conv_pkg::ACC_W-1:0] part_data_i,
   input  logic [conv_pkg::FILTERS-1:0][conv_pkg::BIAS_W-1:0] bias_i,
   output logic                                       part_ready_o,
   input  logic                                       acc_take_i,
   output logic                                       acc_valid_o,
   output logic [conv_pkg::FILTERS-1:0][conv_pkg::POS_OUT-1:0]
                [conv_pkg::DATA_W-1:0]                 acc_data_o
);

   conv_pkg::accum_state_e state;

   logic [conv_pkg::CH_W-1:0] depth;
   logic                      handoff;

   logic [conv_pkg::CH_IN-1:0][conv_pkg::FILTERS-1:0]
         [conv_pkg::POS_OUT-1:0][conv_pkg::ACC_W-1:0] part_q;

   logic [conv_pkg::FILTERS-1:0][conv_pkg::POS_OUT-1:0][conv_pkg::ACC_W-1:0] acc_q;
   logic [conv_pkg::FILTERS-1:0][conv_pkg::ACC_W-1:0]                        bias_ext;

   assign part_ready_o = (state == conv_pkg::ACC_IDLE);
   assign acc_valid_o  = (state == conv_pkg::ACC_HOLD);
   assign handoff      = part_valid_i && part_ready_o;

   // Bias sign extension to accumulator width
   always_comb begin
      for (int f = 0; f < conv_pkg::FILTERS; f++) begin
         bias_ext[f] = {{(conv_pkg::ACC_W - conv_pkg::BIAS_W){bias_i[f][conv_pkg::BIAS_W-1]}},
                        bias_i[f]};
      end
   end

   //////////////////////////////
   // Sequencing
   //////////////////////////////

   always_ff @(posedge clk or posedge rst_n) begin
      if (rst_n) begin
         state <= conv_pkg::ACC_IDLE;
         depth <= '0;
      end else begin
         case (state)
            conv_pkg::ACC_IDLE: begin
               if (handoff) begin
                  state <= conv_pkg::ACC_SUM;
                  depth <= conv_pkg::FIRST_CH;
               end
            end
            conv_pkg::ACC_SUM: begin
               if (depth == conv_pkg::LAST_CH) begin
                  state <= conv_pkg::ACC_BIAS;
               end else begin
                  depth <= depth + 1'b1;
               end
            end
            conv_pkg::ACC_BIAS: state <= conv_pkg::ACC_HOLD;
            conv_pkg::ACC_HOLD: begin
               if (acc_take_i) begin
                  state <= conv_pkg::ACC_IDLE;
               end
            end
            default: state <= conv_pkg::ACC_IDLE;
         endcase
      end
   end

   // Handoff overwrites the old sum with channel 0, which clears it
   always_ff @(posedge clk) begin
      if (handoff) begin
         part_q <= part_data_i;
         acc_q  <= part_data_i[0];
      end else if (state == conv_pkg::ACC_SUM) begin
         for (int f = 0; f < conv_pkg::FILTERS; f++) begin
            for (int p = 0; p < conv_pkg::POS_OUT; p++) begin
               acc_q[f][p] <= acc_q[f][p] + part_q[depth][f][p];
            end
         end
      end else if (state == conv_pkg::ACC_BIAS) begin
         for (int f = 0; f < conv_pkg::FILTERS; f++) begin
            for (int p = 0; p < conv_pkg::POS_OUT; p++) begin
               acc_q[f][p] <= acc_q[f][p] + bias_ext[f];
            end
         end
      end
   end

   //////////////////////////////
   // Saturation to int8
   //////////////////////////////

   always_comb begin
      logic signed [conv_pkg::ACC_W-1:0] v;
      for (int f = 0; f < conv_pkg::FILTERS; f++) begin
         for (int p = 0; p < conv_pkg::POS_OUT; p++) begin
            v = $signed(acc_q[f][p]);
            if (v >= 32'sd127) begin
               acc_data_o[f][p] = 8'h7f;
            end else if (v < -32'sd128) begin
               acc_data_o[f][p] = 8'h80;
            end else begin
               acc_data_o[f][p] = v[conv_pkg::DATA_W-1:0];
            end
         end
      end
   end

endmodule

// ==== conv_layer.sv ====
`timescale 1ns/1ps

module conv_layer (
   input  logic                                       clk,
   input  logic                                       rst_n,
   input  logic                                       wr_en_i,
   input  logic [conv_pkg::WADDR_W-1:0]               wr_addr_i,
   input  logic [conv_pkg::WDATA_W-1:0]               wr_data_i,
   input  logic                                       tile_valid_i,
   input  logic [conv_pkg::CH_IN-1:0][conv_pkg::ROW_LEN-1:0]
                [conv_pkg::DATA_W-1:0]                 tile_data_i,
   output logic                                       tile_credit_o,
   input  logic                                       res_credit_i,
   output logic                                       res_valid_o,
   output logic [conv_pkg::FILTERS-1:0][conv_pkg::POS_OUT-1:0]
                [conv_pkg::DATA_W-1:0]                 res_data_o
);

   logic [conv_pkg::FILTERS-1:0][conv_pkg::CH_IN-1:0]
         [conv_pkg::TAPS-1:0][conv_pkg::DATA_W-1:0] taps;
   logic [conv_pkg::FILTERS-1:0][conv_pkg::BIAS_W-1:0] bias;

   logic [conv_pkg::CH_IN-1:0][conv_pkg::FILTERS-1:0]
         [conv_pkg::POS_OUT-1:0][conv_pkg::ACC_W-1:0] part_data;
   logic part_valid;
   logic part_ready;
   logic tile_done;

   logic [conv_pkg::FILTERS-1:0][conv_pkg::POS_OUT-1:0][conv_pkg::DATA_W-1:0] acc_data;
   logic acc_valid;
   logic acc_take;

   logic [conv_pkg::OUT_CNT_W-1:0] out_cnt;

   conv_weight_store u_store (
      .clk       (clk),
      .rst_n     (rst_n),
      .wr_en_i   (wr_en_i),
      .wr_addr_i (wr_addr_i),
      .wr_data_i (wr_data_i),
      .taps_o    (taps),
      .bias_o    (bias)
   );

   conv_mul u_mul (
      .clk          (clk),
      .rst_n        (rst_n),
      .tile_valid_i (tile_valid_i),
      .tile_data_i  (tile_data_i),
      .taps_i       (taps),
      .part_ready_i (part_ready),
      .part_valid_o (part_valid),
      .part_data_o  (part_data),
      .tile_done_o  (tile_done)
   );

   conv_accum u_accum (
      .clk          (clk),
      .rst_n        (rst_n),
      .part_valid_i (part_valid),
      .part_data_i  (part_data),
      .bias_i       (bias),
      .part_ready_o (part_ready),
      .acc_take_i   (acc_take),
      .acc_valid_o  (acc_valid),
      .acc_data_o   (acc_data)
   );

   // Input credit goes back once the partials move on
   assign tile_credit_o = tile_done;

   //////////////////////////////
   // Output credits
   //////////////////////////////

   assign acc_take = acc_valid && (out_cnt != '0);

   always_ff @(posedge clk or posedge rst_n) begin
      if (rst_n) begin
         out_cnt     <= conv_pkg::OUT_CNT_INIT;
         res_valid_o <= 1'b0;
      end else begin
         res_valid_o <= acc_take;
         // Send and return together cancel out
         if (acc_take && !res_credit_i) begin
            out_cnt <= out_cnt - 1'b1;
         end else if (!acc_take && res_credit_i) begin
            out_cnt <= out_cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (acc_take) begin
         res_data_o <= acc_data;
      end
   end

endmodule

// ==== conv_layer_sva.sv ====
`timescale 1ns/1ps

module conv_layer_sva (
   input logic                           clk,
   input logic                           rst_n,
   input logic                           res_credit_i,
   input logic                           res_valid_i,
   input logic                           tile_credit_i,
   input logic [conv_pkg::OUT_CNT_W-1:0] out_cnt_i
);

   // Credits returned minus results seen at the ports, up to the last edge
   int port_cnt;

   always_ff @(posedge clk or posedge rst_n) begin
      if (rst_n) begin
         port_cnt <= conv_pkg::OUT_CREDITS;
      end else begin
         port_cnt <= port_cnt + int'(res_credit_i) - int'(res_valid_i);
      end
   end

   //////////////////////////////
   // Output credit protocol
   //////////////////////////////

   // A result needs a credit the downstream has not used yet
   assert property (@(posedge clk) disable iff (rst_n)
                    res_valid_i |-> (port_cnt > 0))
      else $error("Result sent with no output credit left");

   assert property (@(posedge clk) disable iff (rst_n)
                    out_cnt_i <= conv_pkg::OUT_CNT_INIT)
      else $error("Output credit count above its reset value");

   //////////////////////////////
   // Input credit and reset
   //////////////////////////////

   assert property (@(posedge clk) disable iff (rst_n)
                    tile_credit_i |=> !tile_credit_i)
      else $error("Tile credit held longer than one cycle");

   // First cycle out of reset
   assert property (@(posedge clk)
                    $fell(rst_n) |-> (!res_valid_i && !tile_credit_i))
      else $error("Outputs active in the first cycle after reset");

endmodule

bind conv_layer conv_layer_sva conv_layer_sva_i (
   .clk           (clk),
   .rst_n         (rst_n),
   .res_credit_i  (res_credit_i),
   .res_valid_i   (res_valid_o),
   .tile_credit_i (tile_credit_o),
   .out_cnt_i     (out_cnt)
);

// ==== conv_mul.sv ====
`timescale 1ns/1ps

module conv_mul (
   input  logic                                       clk,
   input  logic                                       rst_n,
   input  logic                                       tile_valid_i,
   input  logic [conv_pkg::CH_IN-1:0][conv_pkg::ROW_LEN-1:0]
                [conv_pkg::DATA_W-1:0]                 tile_data_i,
   input  logic [conv_pkg::FILTERS-1:0][conv_pkg::CH_IN-1:0]
                [conv_pkg::TAPS-1:0][conv_pkg::DATA_W-1:0] taps_i,
   input  logic                                       part_ready_i,
   output logic                                       part_valid_o,
   output logic [conv_pkg::CH_IN-1:0][conv_pkg::FILTERS-1:0]
                [conv_pkg::POS_OUT-1:0][conv_pkg::ACC_W-1:0] part_data_o,
   output logic                                       tile_done_o
);

   conv_pkg::mul_state_e state;

   logic [conv_pkg::CH_W-1:0] ch_cnt;
   logic                      start;

   logic [conv_pkg::CH_IN-1:0][conv_pkg::ROW_LEN-1:0][conv_pkg::DATA_W-1:0] tile_q;

   logic [conv_pkg::CH_IN-1:0][conv_pkg::FILTERS-1:0]
         [conv_pkg::POS_OUT-1:0][conv_pkg::ACC_W-1:0] part_q;

   // Result for the channel selected by ch_cnt
   logic [conv_pkg::FILTERS-1:0][conv_pkg::POS_OUT-1:0][conv_pkg::ACC_W-1:0] chan_sum;

   assign start = (state == conv_pkg::MUL_IDLE) && tile_valid_i;

   //////////////////////////////
   // Per channel tap products
   //////////////////////////////

   always_comb begin
      logic signed [conv_pkg::ACC_W-1:0] sum;
      for (int f = 0; f < conv_pkg::FILTERS; f++) begin
         for (int p = 0; p < conv_pkg::POS_OUT; p++) begin
            sum = '0;
            // Window of TAPS samples starting at position p
            for (int t = 0; t < conv_pkg::TAPS; t++) begin
               sum = sum + $signed(taps_i[f][ch_cnt][t]) * $signed(tile_q[ch_cnt][p + t]);
            end
            chan_sum[f][p] = sum;
         end
      end
   end

   //////////////////////////////
   // Control FSM
   //////////////////////////////

   always_ff @(posedge clk or posedge rst_n) begin
      if (rst_n) begin
         state  <= conv_pkg::MUL_IDLE;
         ch_cnt <= '0;
      end else begin
         case (state)
            conv_pkg::MUL_IDLE: begin
               if (start) begin
                  state  <= conv_pkg::MUL_RUN;
                  ch_cnt <= '0;
               end
            end
            conv_pkg::MUL_RUN: begin
               if (ch_cnt == conv_pkg::LAST_CH) begin
                  state <= conv_pkg::MUL_WAIT;
               end else begin
                  ch_cnt <= ch_cnt + 1'b1;
               end
            end
            conv_pkg::MUL_WAIT: begin
               // Hold the partials until the accumulator takes them
               if (part_ready_i) begin
                  state <= conv_pkg::MUL_IDLE;
               end
            end
            default: state <= conv_pkg::MUL_IDLE;
         endcase
      end
   end

   // Tile and partial storage
   always_ff @(posedge clk) begin
      if (start) begin
         tile_q <= tile_data_i;
      end
      if (state == conv_pkg::MUL_RUN) begin
         part_q[ch_cnt] <= chan_sum;
      end
   end

   assign part_valid_o = (state == conv_pkg::MUL_WAIT);
   assign part_data_o  = part_q;

   // One cycle pulse, the FSM leaves MUL_WAIT on the next edge
   assign tile_done_o = part_valid_o && part_ready_i;

endmodule

// ==== conv_pkg.sv ====
package conv_pkg;

   //////////////////////////////
   // Layer geometry
   //////////////////////////////

   localparam int CH_IN   = 4;
   localparam int POS_OUT = 6;
   localparam int TAPS    = 3;
   localparam int FILTERS = 4;
   localparam int ROW_LEN = POS_OUT + TAPS - 1;

   // Signed pixel, tap, accumulator and bias widths
   localparam int DATA_W = 8;
   localparam int ACC_W  = 32;
   localparam int BIAS_W = 16;

   // Counter widths for channel and filter selects
   localparam int CH_W   = $clog2(CH_IN);
   localparam int FILT_W = $clog2(FILTERS);

   localparam logic [CH_W-1:0] LAST_CH  = CH_W'(CH_IN - 1);
   localparam logic [CH_W-1:0] FIRST_CH = CH_W'(1);

   //////////////////////////////
   // Weight store address map
   //////////////////////////////

   localparam int WADDR_W   = 6;
   localparam int WDATA_W   = 16;
   localparam int TAP_WORDS = FILTERS * CH_IN * TAPS;

   // Taps at 0..47 then one bias per filter
   localparam logic [WADDR_W-1:0] BIAS_ADDR = WADDR_W'(TAP_WORDS);
   localparam logic [WADDR_W-1:0] BIAS_END  = WADDR_W'(TAP_WORDS + FILTERS);

   // Credits held after reset
   localparam int IN_CREDITS  = 1;
   localparam int OUT_CREDITS = 2;
   localparam int OUT_CNT_W   = $clog2(OUT_CREDITS + 1);

   localparam logic [OUT_CNT_W-1:0] OUT_CNT_INIT = OUT_CNT_W'(OUT_CREDITS);

   typedef enum logic [1:0] {ACC_IDLE, ACC_SUM, ACC_BIAS, ACC_HOLD} accum_state_e;
   typedef enum logic [1:0] {MUL_IDLE, MUL_RUN, MUL_WAIT} mul_state_e;

endpackage

// ==== conv_weight_store.sv ====
`timescale 1ns/1ps

module conv_weight_store (
   input  logic                                       clk,
   input  logic                                       rst_n,
   input  logic                                       wr_en_i,
   input  logic [conv_pkg::WADDR_W-1:0]               wr_addr_i,
   input  logic [conv_pkg::WDATA_W-1:0]               wr_data_i,
   output logic [conv_pkg::FILTERS-1:0][conv_pkg::CH_IN-1:0]
                [conv_pkg::TAPS-1:0][conv_pkg::DATA_W-1:0] taps_o,
   output logic [conv_pkg::FILTERS-1:0][conv_pkg::BIAS_W-1:0] bias_o
);

   // Flat tap array, filter major, then channel, then tap
   logic [conv_pkg::TAP_WORDS-1:0][conv_pkg::DATA_W-1:0] tap_q;
   logic [conv_pkg::FILTERS-1:0][conv_pkg::BIAS_W-1:0]   bias_q;

   logic                         tap_sel;
   logic                         bias_sel;
   logic [conv_pkg::WADDR_W-1:0] bias_off;

   //////////////////////////////
   // Address decode
   //////////////////////////////

   assign tap_sel  = wr_en_i && (wr_addr_i < conv_pkg::BIAS_ADDR);
   assign bias_sel = wr_en_i && (wr_addr_i >= conv_pkg::BIAS_ADDR)
                     && (wr_addr_i < conv_pkg::BIAS_END);

   // Bias slot relative to the first bias word
   assign bias_off = wr_addr_i - conv_pkg::BIAS_ADDR;

   always_ff @(posedge clk or posedge rst_n) begin
      if (rst_n) begin
         tap_q  <= '0;
         bias_q <= '0;
      end else begin
         if (tap_sel) begin
            // Taps keep only the low byte
            tap_q[wr_addr_i] <= wr_data_i[conv_pkg::DATA_W-1:0];
         end
         if (bias_sel) begin
            bias_q[bias_off[conv_pkg::FILT_W-1:0]] <= wr_data_i[conv_pkg::BIAS_W-1:0];
         end
         // Anything past the last bias is dropped
      end
   end

   // Same bit order as the flat array
   assign taps_o = tap_q;
   assign bias_o = bias_q;

endmodule

// ==== flist.f ====
conv_pkg.sv
conv_weight_store.sv
conv_mul.sv
conv_accum.sv
conv_layer.sv
conv_layer_sva.sv
tb_clock_gen.sv
tb_conv_layer.sv

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
   output logic clk_o,
   output logic rst_n_o
);

   // 20 ns period
   initial clk_o = 1'b0;
   always #10 clk_o = ~clk_o;

   // Reset is high for the first 3 rising edges
   initial begin
      rst_n_o = 1'b1;
      repeat (3) @(posedge clk_o);
      rst_n_o <= 1'b0;
   end

endmodule

// ==== tb_conv_layer.sv ====
`timescale 1ns/1ps

module tb_conv_layer;

   typedef logic [conv_pkg::CH_IN-1:0][conv_pkg::ROW_LEN-1:0][conv_pkg::DATA_W-1:0] tile_t;
   typedef logic [conv_pkg::FILTERS-1:0][conv_pkg::POS_OUT-1:0][conv_pkg::DATA_W-1:0] res_t;

   // Stall free latency, about 200 tiles, wide margin for credit stalls
   localparam int LAT        = 2 * conv_pkg::CH_IN + 3;
   localparam int MAX_CYCLES = 200 * LAT * 18;

   logic clk;
   logic rst_n;
   logic wr_en;
   logic [conv_pkg::WADDR_W-1:0] wr_addr;
   logic [conv_pkg::WDATA_W-1:0] wr_data;
   logic  tile_valid;
   tile_t tile_data;
   logic  tile_credit;
   logic  res_credit;
   logic  res_valid;
   res_t  res_data;

   // Reference copy of the weight store
   logic signed [7:0]  m_tap [conv_pkg::FILTERS][conv_pkg::CH_IN][conv_pkg::TAPS];
   logic signed [15:0] m_bias [conv_pkg::FILTERS];

   res_t   exp_q[$];
   integer seed;
   int     in_cred;
   int     owed;
   int     sent;
   int     credits_back;
   int     rx_cnt;
   int     sat_hi;
   int     sat_lo;
   int     val_errs;
   int     other_errs;
   int     base;
   bit     hold_credits;

   tb_clock_gen clock_gen_i (
      .clk_o   (clk),
      .rst_n_o (rst_n)
   );

   conv_layer conv_layer_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .wr_en_i       (wr_en),
      .wr_addr_i     (wr_addr),
      .wr_data_i     (wr_data),
      .tile_valid_i  (tile_valid),
      .tile_data_i   (tile_data),
      .tile_credit_o (tile_credit),
      .res_credit_i  (res_credit),
      .res_valid_o   (res_valid),
      .res_data_o    (res_data)
   );

   //////////////////////////////
   // Reference model
   //////////////////////////////

   function automatic res_t model(tile_t tile);
      res_t res;
      int   acc;
      for (int f = 0; f < conv_pkg::FILTERS; f++) begin
         for (int p = 0; p < conv_pkg::POS_OUT; p++) begin
            acc = int'(m_bias[f]);
            for (int c = 0; c < conv_pkg::CH_IN; c++) begin
               for (int t = 0; t < conv_pkg::TAPS; t++) begin
                  acc += int'(m_tap[f][c][t]) * int'($signed(tile[c][p + t]));
               end
            end
            if (acc >= 127) res[f][p] = 8'h7f;
            else if (acc < -128) res[f][p] = 8'h80;
            else res[f][p] = acc[7:0];
         end
      end
      return res;
   endfunction

   // Small values for span, else magnitudes 96 to 127 of random sign
   function automatic tile_t rand_tile(int span, bit big);
      tile_t tile;
      int    r;
      for (int c = 0; c < conv_pkg::CH_IN; c++) begin
         for (int i = 0; i < conv_pkg::ROW_LEN; i++) begin
            if (big) begin
               r = 96 + ($random(seed) & 31);
               if ($random(seed) & 1) r = -r;
            end else begin
               r = $random(seed) % span;
            end
            tile[c][i] = r[7:0];
         end
      end
      return tile;
   endfunction

   //////////////////////////////
   // Per cycle bookkeeping
   //////////////////////////////

   task automatic cycle();
      res_t exp;
      @(posedge clk);
      tile_valid <= 1'b0;
      wr_en      <= 1'b0;
      res_credit <= 1'b0;
      if (tile_credit) begin
         in_cred++;
         credits_back++;
         if (in_cred > conv_pkg::IN_CREDITS) begin
            other_errs++;
            $display("Input credit returned with no tile in flight at %0t", $time);
         end
      end
      if (res_valid) begin
         if (exp_q.size() == 0) begin
            other_errs++;
            $display("Result arrived with none expected at %0t", $time);
         end else begin
            exp = exp_q.pop_front();
            if (res_data !== exp) begin
               val_errs++;
               $display("ERR %0t result %0d: got %h expected %h", $time, rx_cnt, res_data, exp);
            end
         end
         for (int f = 0; f < conv_pkg::FILTERS; f++) begin
            for (int p = 0; p < conv_pkg::POS_OUT; p++) begin
               if (res_data[f][p] == 8'h7f) sat_hi++;
               if (res_data[f][p] == 8'h80) sat_lo++;
            end
         end
         rx_cnt++;
         owed++;
      end
      // Output credits go back after a random delay
      if (!hold_credits && owed > 0 && ($random(seed) & 3) == 0) begin
         res_credit <= 1'b1;
         owed--;
      end
   endtask

   task automatic write_word(int addr, logic [15:0] data);
      logic [conv_pkg::WADDR_W-1:0] a;
      a = addr[conv_pkg::WADDR_W-1:0];
      cycle();
      wr_en   <= 1'b1;
      wr_addr <= a;
      wr_data <= data;
   endtask

   // Upper byte of a tap word is junk
   task automatic load_filter(int f, int tspan, int bspan);
      int r;
      int junk;
      for (int c = 0; c < conv_pkg::CH_IN; c++) begin
         for (int t = 0; t < conv_pkg::TAPS; t++) begin
            r    = $random(seed) % tspan;
            junk = $random(seed);
            m_tap[f][c][t] = r[7:0];
            write_word((f * conv_pkg::CH_IN + c) * conv_pkg::TAPS + t, {junk[7:0], r[7:0]});
         end
      end
      r = $random(seed) % bspan;
      m_bias[f] = r[15:0];
      write_word(int'(conv_pkg::BIAS_ADDR) + f, r[15:0]);
   endtask

   task automatic load_all(int tspan, int bspan);
      int junk;
      for (int f = 0; f < conv_pkg::FILTERS; f++) load_filter(f, tspan, bspan);
      // Past the map, must leave the store alone
      junk = $random(seed);
      write_word(int'(conv_pkg::BIAS_END) + (junk & 7), junk[15:0]);
   endtask

   task automatic send_tile(tile_t tile);
      cycle();
      while (in_cred == 0) cycle();
      tile_valid <= 1'b1;
      tile_data  <= tile;
      in_cred--;
      sent++;
      exp_q.push_back(model(tile));
   endtask

   task automatic send_burst(int n, int span, bit big);
      for (int i = 0; i < n; i++) send_tile(rand_tile(span, big));
   endtask

   task automatic drain();
      do cycle(); while (exp_q.size() != 0 || owed != 0);
   endtask

   //////////////////////////////
   // Test sequence
   //////////////////////////////

   initial begin
      seed = 32'h48a7b7b5;
      wr_en = 1'b0;
      wr_addr = '0;
      wr_data = '0;
      tile_valid = 1'b0;
      tile_data = '0;
      res_credit = 1'b0;
      hold_credits = 1'b0;
      in_cred = conv_pkg::IN_CREDITS;
      {owed, sent, credits_back, rx_cnt, sat_hi, sat_lo, val_errs, other_errs} = '0;
      for (int f = 0; f < conv_pkg::FILTERS; f++) begin
         m_bias[f] = '0;
         for (int c = 0; c < conv_pkg::CH_IN; c++) begin
            for (int t = 0; t < conv_pkg::TAPS; t++) m_tap[f][c][t] = '0;
         end
      end
      @(negedge rst_n);

      // Store still cleared from reset
      send_burst(8, 128, 1'b0);
      drain();
      load_all(4, 64);
      send_burst(100, 4, 1'b0);
      drain();
      // New taps and bias for filter 2 only
      load_filter(2, 8, 200);
      send_burst(40, 4, 1'b0);
      drain();
      load_all(128, 4096);
      // Saturation counted over the large tiles alone
      sat_hi = 0;
      sat_lo = 0;
      send_burst(40, 0, 1'b1);
      drain();
      if (sat_hi == 0 || sat_lo == 0) begin
         other_errs++;
         $display("Saturation limits not both reached: %0d high, %0d low", sat_hi, sat_lo);
      end

      // Downstream stops returning credits
      hold_credits = 1'b1;
      base = rx_cnt;
      send_burst(4, 16, 1'b0);
      repeat (60) cycle();
      if (rx_cnt - base != conv_pkg::OUT_CREDITS) begin
         other_errs++;
         $display("%0d results came out with credits withheld, expected %0d",
                  rx_cnt - base, conv_pkg::OUT_CREDITS);
      end
      hold_credits = 1'b0;
      drain();

      if (credits_back != sent) begin
         other_errs++;
         $display("%0d input credits returned for %0d tiles sent", credits_back, sent);
      end
      $display("Results %0d, value errors %0d, other errors %0d", rx_cnt, val_errs, other_errs);
      if (val_errs == 0 && other_errs == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   // Watchdog
   initial begin : watchdog
      int n;
      n = 0;
      while (n < MAX_CYCLES) begin
         @(posedge clk);
         n++;
      end
      $display("Timeout: no finish after %0d cycles, %0d results pending", n, exp_q.size());
      $display("Simulation failed");
      $finish;
   end

endmodule
